// ==== Bender.yml ====
package:
  name: async_fifo

sources:
  - hw/fifo_cfg_pkg.sv
  - hw/fifo_port_pkg.sv
  - hw/fifo_dual_port_ram.sv
  - hw/fifo_wr_ctrl.sv
  - hw/fifo_rd_ctrl.sv
  - hw/async_fifo.sv
  - target: test
    files:
      - tb/async_fifo_tb.sv

// ==== async_fifo.f ====
hw/fifo_cfg_pkg.sv
hw/fifo_port_pkg.sv
hw/fifo_dual_port_ram.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/async_fifo.sv
tb/async_fifo_tb.sv

// ==== hw/async_fifo.sv ====
module async_fifo (
  input  logic                         wr_clk,
  input  logic                         rd_clk,
  input  logic                         wr_rst_n,
  input  fifo_port_pkg::fifo_wr_req_t  wr_req,
  output fifo_port_pkg::fifo_wr_stat_t wr_stat,
  input  logic                         rd_en,
  output fifo_cfg_pkg::data_t          rd_data,
  output fifo_port_pkg::fifo_rd_stat_t rd_stat
);

  logic                wr_en;
  fifo_cfg_pkg::addr_t wr_addr;
  logic                ram_rd_en;
  fifo_cfg_pkg::addr_t rd_addr;

  // the only signals crossing between the clock domains
  fifo_cfg_pkg::ptr_t  wr_ptr_gray;
  fifo_cfg_pkg::ptr_t  rd_ptr_gray;

  fifo_dual_port_ram u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_req.data),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_req      (wr_req),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_stat     (wr_stat)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .ram_rd_en   (ram_rd_en),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_stat     (rd_stat)
  );

endmodule

// ==== hw/fifo_cfg_pkg.sv ====
package fifo_cfg_pkg;

  // word and storage sizes
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // flag thresholds, in words
  localparam int FIFO_AFULL  = 12;
  localparam int FIFO_AEMPTY = 2;

  // flops per synchronizer chain, pointers and reset alike
  localparam int SYNC_STAGES = 2;

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // extra top bit is the wrap flag, used binary and gray coded
  typedef logic [ADDR_WIDTH:0] ptr_t;

  // occupancy 0..FIFO_DEPTH
  typedef logic [ADDR_WIDTH:0] level_t;

endpackage

// ==== hw/fifo_dual_port_ram.sv ====
module fifo_dual_port_ram (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  fifo_cfg_pkg::addr_t wr_addr,
  input  fifo_cfg_pkg::data_t wr_data,
  input  logic                rd_clk,
  input  logic                wr_rst_n,
  input  logic                rd_en,
  input  fifo_cfg_pkg::addr_t rd_addr,
  output fifo_cfg_pkg::data_t rd_data
);

  fifo_cfg_pkg::data_t mem [fifo_cfg_pkg::FIFO_DEPTH];

  // write port
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, holds until the next pop
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/fifo_port_pkg.sv ====
package fifo_port_pkg;

  // write side request, sampled on wr_clk
  typedef struct packed {
    logic                en;
    fifo_cfg_pkg::data_t data;
  } fifo_wr_req_t;

  // write side flags, registered on wr_clk
  typedef struct packed {
    logic full;
    logic afull;
  } fifo_wr_stat_t;

  // read side flags, registered on rd_clk
  typedef struct packed {
    logic empty;
    logic aempty;
  } fifo_rd_stat_t;

endpackage

// ==== hw/fifo_rd_ctrl.sv ====
module fifo_rd_ctrl (
  input  logic                         rd_clk,
  input  logic                         wr_rst_n,
  input  logic                         rd_en,
  input  fifo_cfg_pkg::ptr_t           wr_ptr_gray,
  output logic                         ram_rd_en,
  output fifo_cfg_pkg::addr_t          rd_addr,
  output fifo_cfg_pkg::ptr_t           rd_ptr_gray,
  output fifo_port_pkg::fifo_rd_stat_t rd_stat
);

  logic [fifo_cfg_pkg::SYNC_STAGES-1:0] rst_sync_q;
  logic                                 rst_n;

  fifo_cfg_pkg::ptr_t   rd_ptr_bin;
  fifo_cfg_pkg::ptr_t   rd_ptr_bin_nxt;
  fifo_cfg_pkg::ptr_t   rd_ptr_gray_nxt;
  fifo_cfg_pkg::ptr_t   wr_gray_sync [fifo_cfg_pkg::SYNC_STAGES];
  fifo_cfg_pkg::ptr_t   wr_ptr_bin;
  fifo_cfg_pkg::level_t level;
  fifo_cfg_pkg::level_t level_nxt;

  // async assert, release synchronized to rd_clk
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[fifo_cfg_pkg::SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[fifo_cfg_pkg::SYNC_STAGES-1];

  assign ram_rd_en       = rd_en & ~rd_stat.empty;
  assign rd_ptr_bin_nxt  = rd_ptr_bin + fifo_cfg_pkg::ptr_t'(ram_rd_en);
  assign rd_ptr_gray_nxt = rd_ptr_bin_nxt ^ (rd_ptr_bin_nxt >> 1);
  assign rd_addr         = rd_ptr_bin[fifo_cfg_pkg::ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt;
    end
  end

  // write pointer crossing into rd_clk
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < fifo_cfg_pkg::SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_ptr_gray;
      for (int i = 1; i < fifo_cfg_pkg::SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

  always_comb begin
    wr_ptr_bin[fifo_cfg_pkg::ADDR_WIDTH] =
      wr_gray_sync[fifo_cfg_pkg::SYNC_STAGES-1][fifo_cfg_pkg::ADDR_WIDTH];
    for (int i = fifo_cfg_pkg::ADDR_WIDTH - 1; i >= 0; i--) begin
      wr_ptr_bin[i] = wr_ptr_bin[i+1] ^ wr_gray_sync[fifo_cfg_pkg::SYNC_STAGES-1][i];
    end
  end

  // stale write pointer only understates the level
  assign level     = wr_ptr_bin - rd_ptr_bin;
  assign level_nxt = wr_ptr_bin - rd_ptr_bin_nxt;

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_stat <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_stat.empty  <= (rd_ptr_bin_nxt == wr_ptr_bin);
      rd_stat.aempty <= (level_nxt <= fifo_cfg_pkg::level_t'(fifo_cfg_pkg::FIFO_AEMPTY));
    end
  end

  a_no_read_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    !(ram_rd_en && level == '0)
  );

  // a negative level wraps above the depth
  a_no_underrun: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    level <= fifo_cfg_pkg::level_t'(fifo_cfg_pkg::FIFO_DEPTH)
  );

endmodule

// ==== hw/fifo_wr_ctrl.sv ====
module fifo_wr_ctrl (
  input  logic                         wr_clk,
  input  logic                         wr_rst_n,
  input  fifo_port_pkg::fifo_wr_req_t  wr_req,
  input  fifo_cfg_pkg::ptr_t           rd_ptr_gray,
  output logic                         wr_en,
  output fifo_cfg_pkg::addr_t          wr_addr,
  output fifo_cfg_pkg::ptr_t           wr_ptr_gray,
  output fifo_port_pkg::fifo_wr_stat_t wr_stat
);

  logic [fifo_cfg_pkg::SYNC_STAGES-1:0] rst_sync_q;
  logic                                 rst_n;

  fifo_cfg_pkg::ptr_t   wr_ptr_bin;
  fifo_cfg_pkg::ptr_t   wr_ptr_bin_nxt;
  fifo_cfg_pkg::ptr_t   wr_ptr_gray_nxt;
  fifo_cfg_pkg::ptr_t   rd_gray_sync [fifo_cfg_pkg::SYNC_STAGES];
  fifo_cfg_pkg::ptr_t   rd_ptr_bin;
  fifo_cfg_pkg::level_t level;
  fifo_cfg_pkg::level_t level_nxt;

  // async assert, release synchronized to wr_clk
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[fifo_cfg_pkg::SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[fifo_cfg_pkg::SYNC_STAGES-1];

  assign wr_en           = wr_req.en & ~wr_stat.full;
  assign wr_ptr_bin_nxt  = wr_ptr_bin + fifo_cfg_pkg::ptr_t'(wr_en);
  assign wr_ptr_gray_nxt = wr_ptr_bin_nxt ^ (wr_ptr_bin_nxt >> 1);
  assign wr_addr         = wr_ptr_bin[fifo_cfg_pkg::ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt;
    end
  end

  // read pointer crossing into wr_clk
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < fifo_cfg_pkg::SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_ptr_gray;
      for (int i = 1; i < fifo_cfg_pkg::SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  // gray to binary, msb first
  always_comb begin
    rd_ptr_bin[fifo_cfg_pkg::ADDR_WIDTH] =
      rd_gray_sync[fifo_cfg_pkg::SYNC_STAGES-1][fifo_cfg_pkg::ADDR_WIDTH];
    for (int i = fifo_cfg_pkg::ADDR_WIDTH - 1; i >= 0; i--) begin
      rd_ptr_bin[i] = rd_ptr_bin[i+1] ^ rd_gray_sync[fifo_cfg_pkg::SYNC_STAGES-1][i];
    end
  end

  // stale read pointer only overstates the level
  assign level     = wr_ptr_bin - rd_ptr_bin;
  assign level_nxt = wr_ptr_bin_nxt - rd_ptr_bin;

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_stat <= '0;
    end else begin
      wr_stat.full  <= (level_nxt == fifo_cfg_pkg::level_t'(fifo_cfg_pkg::FIFO_DEPTH));
      wr_stat.afull <= (level_nxt >= fifo_cfg_pkg::level_t'(fifo_cfg_pkg::FIFO_AFULL));
    end
  end

  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    !(wr_en && level == fifo_cfg_pkg::level_t'(fifo_cfg_pkg::FIFO_DEPTH))
  );

  // the read side relies on this to sample a coherent pointer
  a_wr_gray_one_bit: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  );

endmodule

// ==== tb/async_fifo_tb.sv ====
module async_fifo_tb;

  localparam int TIMEOUT = 2000;

  logic                         wr_clk;
  logic                         rd_clk;
  logic                         wr_rst_n;
  fifo_port_pkg::fifo_wr_req_t  wr_req;
  fifo_port_pkg::fifo_wr_stat_t wr_stat;
  logic                         rd_en;
  fifo_cfg_pkg::data_t          rd_data;
  fifo_port_pkg::fifo_rd_stat_t rd_stat;

  int    wr_count;
  int    rd_count;
  bit    rd_fire;
  int    errors;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;
  string test_name;

  async_fifo dut (.*);

  always #5 rd_clk = ~rd_clk;
  // wr_clk runs at a different period so the phases drift
  always #7 wr_clk = ~wr_clk;

  // n-th word ever written, odd multiplier keeps 256 words distinct
  function automatic fifo_cfg_pkg::data_t expected_word(input int n);
    return fifo_cfg_pkg::data_t'((n * 37) ^ 8'h5a);
  endfunction

  task automatic check_value(input string what, input int exp, input int got);
    assert (got == exp) else begin
      $display("mismatch %s %s expected %0h actual %0h", test_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout in %s: %s within %0d cycles", test_name, what, TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  task automatic settle();
    repeat (10) @(negedge wr_clk);
    repeat (10) @(negedge rd_clk);
  endtask

  task automatic check_idle_flags(input string when);
    check_value({"full ", when}, 0, wr_stat.full);
    check_value({"afull ", when}, 0, wr_stat.afull);
    check_value({"empty ", when}, 1, rd_stat.empty);
    check_value({"aempty ", when}, 1, rd_stat.aempty);
  endtask

  // full is stable at the falling edge, so it decides the next rising edge
  task automatic write_words(input int count, input bit gaps);
    int done;
    int waited;
    done = 0;
    waited = 0;
    while (done < count) begin
      @(negedge wr_clk);
      if (gaps && $urandom_range(3) == 0) begin
        wr_req.en = 1'b0;
      end else begin
        wr_req.en = 1'b1;
        wr_req.data = expected_word(wr_count);
        if (!wr_stat.full) begin
          wr_count++;
          done++;
          waited = 0;
        end else begin
          waited++;
          if (waited > TIMEOUT) timed_out("write side stuck at full");
        end
      end
    end
    @(negedge wr_clk);
    wr_req.en = 1'b0;
  endtask

  task automatic read_words(input int count, input int one_in);
    int done;
    int waited;
    done = 0;
    waited = 0;
    while (done < count) begin
      @(negedge rd_clk);
      rd_en = ($urandom_range(one_in - 1) == 0);
      rd_fire = rd_en && !rd_stat.empty;
      if (rd_fire) begin
        done++;
        waited = 0;
      end else begin
        waited++;
        if (waited > TIMEOUT) timed_out("read side never saw data");
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    rd_fire = 1'b0;
  endtask

  task automatic fill_until_full(output int accepted);
    int waited;
    accepted = 0;
    waited = 0;
    @(negedge wr_clk);
    while (!wr_stat.full) begin
      wr_req.en = 1'b1;
      wr_req.data = expected_word(wr_count);
      wr_count++;
      accepted++;
      waited++;
      if (waited > TIMEOUT) timed_out("fifo never reported full");
      @(negedge wr_clk);
    end
    // hold the next word while blocked
    wr_req.data = expected_word(wr_count);
  endtask

  task automatic read_until_empty(output int popped);
    int waited;
    popped = 0;
    waited = 0;
    @(negedge rd_clk);
    while (!rd_stat.empty) begin
      rd_en = 1'b1;
      rd_fire = 1'b1;
      popped++;
      waited++;
      if (waited > TIMEOUT) timed_out("fifo never reported empty");
      @(negedge rd_clk);
    end
    rd_en = 1'b0;
    rd_fire = 1'b0;
  endtask

  // a pop at one rising edge is checked at the falling edge after it
  initial begin : compare
    bit fired;
    forever begin
      @(posedge rd_clk);
      fired = rd_fire;
      @(negedge rd_clk);
      if (fired) begin
        check_value($sformatf("word %0d", rd_count), expected_word(rd_count), rd_data);
        rd_count++;
      end
    end
  end

  initial begin : main
    int level;
    int filled;
    int popped;
    int steps [5];
    fifo_cfg_pkg::data_t held;
    void'($urandom(32'hadecfb55));
    wr_clk = 1'b0;
    rd_clk = 1'b0;
    wr_rst_n = 1'b0;
    wr_req = '0;
    rd_en = 1'b0;
    rd_fire = 1'b0;
    wr_count = 0;
    rd_count = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;

    begin_test("reset_state");
    repeat (4) @(negedge rd_clk);
    check_idle_flags("in reset");
    repeat (4) @(negedge rd_clk);
    wr_rst_n = 1'b1;
    @(negedge rd_clk);
    check_idle_flags("after reset");
    settle();
    check_idle_flags("after sync");
    end_test();

    begin_test("ordered_transfer");
    fork
      write_words(200, 1'b1);
      read_words(200, 2);
    join
    settle();
    check_value("popped count", wr_count, rd_count);
    end_test();

    begin_test("fill_to_full");
    fill_until_full(filled);
    check_value("accepted at full", fifo_cfg_pkg::FIFO_DEPTH, filled);
    repeat (5) begin
      @(negedge wr_clk);
      check_value("full while blocked", 1, wr_stat.full);
    end
    wr_req.en = 1'b0;
    end_test();

    begin_test("drain_to_empty");
    read_until_empty(popped);
    settle();
    check_value("popped after fill", filled, popped);
    check_value("popped count", wr_count, rd_count);
    held = rd_data;
    repeat (5) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
      rd_fire = !rd_stat.empty;
      check_value("empty while reading", 1, rd_stat.empty);
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    rd_fire = 1'b0;
    settle();
    check_value("rd_data after empty reads", held, rd_data);
    check_value("popped after empty reads", wr_count, rd_count);
    end_test();

    begin_test("thresholds");
    steps = '{0, fifo_cfg_pkg::FIFO_AEMPTY, fifo_cfg_pkg::FIFO_AEMPTY + 1,
              fifo_cfg_pkg::FIFO_AFULL - 1, fifo_cfg_pkg::FIFO_AFULL};
    level = 0;
    foreach (steps[i]) begin
      write_words(steps[i] - level, 1'b0);
      level = steps[i];
      settle();
      check_value($sformatf("afull k=%0d", level),
                  level >= fifo_cfg_pkg::FIFO_AFULL, wr_stat.afull);
      check_value($sformatf("aempty k=%0d", level),
                  level <= fifo_cfg_pkg::FIFO_AEMPTY, rd_stat.aempty);
      check_value($sformatf("full k=%0d", level),
                  level == fifo_cfg_pkg::FIFO_DEPTH, wr_stat.full);
      check_value($sformatf("empty k=%0d", level), level == 0, rd_stat.empty);
    end
    read_words(level, 1);
    settle();
    check_value("popped count", wr_count, rd_count);
    end_test();

    begin_test("back_pressure");
    fork
      write_words(500, 1'b0);
      read_words(500, 4);
    join
    settle();
    check_value("popped count", wr_count, rd_count);
    check_value("empty at end", 1, rd_stat.empty);
    end_test();

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
